//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path word
`define CPU_DATA_W      16

// Memory and PC address
`define CPU_ADDR_W      9
`define CPU_MEM_DEPTH   512

// Register index, eight general registers
`define CPU_REG_IDX_W   3

// Signed branch offset field of BRD
`define CPU_OFFSET_W    10

`endif

//--- cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0]           word_t;
    typedef logic [`CPU_ADDR_W-1:0]           addr_t;
    typedef logic [`CPU_REG_IDX_W-1:0]        reg_idx_t;
    typedef logic signed [`CPU_OFFSET_W-1:0]  offset_t;
    typedef logic [3:0]                       flags_t;  // {V, N, C, Z}

    // Opcode field, IR[15:12]
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,  OP_HLT = 4'd1,  OP_LDI = 4'd2,  OP_LD  = 4'd3,
        OP_ST  = 4'd4,  OP_OUT = 4'd5,  OP_JPL = 4'd6,  OP_RET = 4'd7,
        OP_BRD = 4'd8,  OP_ADD = 4'd9,  OP_SUB = 4'd10, OP_AND = 4'd11,
        OP_OR  = 4'd12, OP_XOR = 4'd13
    } opcode_t;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_t;

    // Sequencer states
    typedef enum logic [2:0] {
        S_IDLE, S_CLEAR, S_FETCH_ADDR, S_FETCH_IR, S_DECODE, S_EXECUTE
    } seq_state_t;

    // Datapath selects
    typedef enum logic [1:0] {PC_SRC_INC, PC_SRC_BRANCH, PC_SRC_REG, PC_SRC_LINK} pc_src_t;
    typedef enum logic [1:0] {WB_SRC_IMM, WB_SRC_MEM, WB_SRC_ALU} wb_src_t;
    typedef enum logic {ADDR_SRC_PC, ADDR_SRC_IMM} addr_src_t;
    typedef enum logic {OUT_SRC_MEM, OUT_SRC_REG} out_src_t;

endpackage

//--- seq_control.sv
`timescale 1ns/1ps

module seq_control (
    input  logic                Clk,
    input  logic                rst_n,
    input  logic                start,
    input  cpu_pkg::word_t      mem_rdata,
    input  cpu_pkg::flags_t     flags,
    output logic                busy,
    output logic                halted,
    output logic                pc_clear,
    output logic                pc_inc,
    output logic                pc_load,
    output logic                link_load,
    output cpu_pkg::pc_src_t    pc_src,
    output cpu_pkg::offset_t    branch_offset,
    output logic                mem_en,
    output logic                mem_we,
    output cpu_pkg::addr_src_t  addr_src,
    output cpu_pkg::addr_t      imm,
    output logic                reg_we,
    output cpu_pkg::wb_src_t    wb_src,
    output cpu_pkg::reg_idx_t   rd_idx,
    output cpu_pkg::reg_idx_t   rs1_idx,
    output cpu_pkg::reg_idx_t   rs2_idx,
    output logic                out_load,
    output cpu_pkg::out_src_t   out_src,
    output cpu_pkg::alu_op_t    alu_op,
    output logic                alu_load,
    output logic                flags_load,
    output logic                flags_clear
);

    cpu_pkg::word_t      ir;           // Instruction register
    cpu_pkg::seq_state_t state;
    cpu_pkg::seq_state_t next_state;
    cpu_pkg::opcode_t    opcode;
    logic                ir_load;
    logic                halt_set;
    logic                alu_pend;     // ALU write-back owed in EXECUTE
    logic                alu_pend_set;
    logic                is_alu;
    logic                take_branch;

    // Instruction fields
    assign opcode        = cpu_pkg::opcode_t'(ir[15:12]);
    assign branch_offset = ir[9:0];
    assign imm           = ir[8:0];
    assign rd_idx        = ir[11:9];
    assign rs2_idx       = ir[6:4];
    assign rs1_idx       = (opcode == cpu_pkg::OP_ST) ? ir[11:9] : ir[2:0];  // ST data reg
    assign busy          = (state != cpu_pkg::S_IDLE);

    // Branch condition, IR[11:10]
    always_comb begin
        case (ir[11:10])
            2'd0:    take_branch = flags[0];             // EQ
            2'd1:    take_branch = ~flags[0];            // NE
            2'd2:    take_branch = flags[2] ^ flags[3];  // LT, N != V
            default: take_branch = flags[1];             // CS
        endcase
    end

    // ------------------------------------------------------------------
    // Control decode per state
    // ------------------------------------------------------------------
    always_comb begin
        next_state   = state;
        ir_load      = 1'b0;
        halt_set     = 1'b0;
        alu_pend_set = 1'b0;
        is_alu       = 1'b0;
        pc_clear     = 1'b0;
        pc_inc       = 1'b0;
        pc_load      = 1'b0;
        link_load    = 1'b0;
        pc_src       = cpu_pkg::PC_SRC_INC;
        mem_en       = 1'b0;
        mem_we       = 1'b0;
        addr_src     = cpu_pkg::ADDR_SRC_PC;
        reg_we       = 1'b0;
        wb_src       = cpu_pkg::WB_SRC_IMM;
        out_load     = 1'b0;
        out_src      = cpu_pkg::OUT_SRC_MEM;
        alu_op       = cpu_pkg::ALU_ADD;
        alu_load     = 1'b0;
        flags_load   = 1'b0;
        flags_clear  = 1'b0;
        case (state)
            cpu_pkg::S_IDLE: begin
                if (start) next_state = cpu_pkg::S_CLEAR;
            end
            cpu_pkg::S_CLEAR: begin
                pc_clear    = 1'b1;
                flags_clear = 1'b1;
                next_state  = cpu_pkg::S_FETCH_ADDR;
            end
            cpu_pkg::S_FETCH_ADDR: begin
                mem_en     = 1'b1;                   // Read at PC
                next_state = cpu_pkg::S_FETCH_IR;
            end
            cpu_pkg::S_FETCH_IR: begin
                ir_load    = 1'b1;
                pc_inc     = 1'b1;                   // Bump PC while IR loads
                next_state = cpu_pkg::S_DECODE;
            end
            cpu_pkg::S_DECODE: begin
                next_state = cpu_pkg::S_FETCH_ADDR;
                case (opcode)
                    cpu_pkg::OP_HLT: begin
                        halt_set   = 1'b1;
                        next_state = cpu_pkg::S_IDLE;
                    end
                    cpu_pkg::OP_LDI: reg_we = 1'b1;  // Zero-extended immediate
                    cpu_pkg::OP_LD: begin
                        mem_en     = 1'b1;
                        addr_src   = cpu_pkg::ADDR_SRC_IMM;
                        next_state = cpu_pkg::S_EXECUTE;
                    end
                    cpu_pkg::OP_ST: begin
                        mem_en   = 1'b1;
                        mem_we   = 1'b1;
                        addr_src = cpu_pkg::ADDR_SRC_IMM;
                    end
                    cpu_pkg::OP_OUT: begin
                        if (ir[11]) begin            // From register
                            out_load = 1'b1;
                            out_src  = cpu_pkg::OUT_SRC_REG;
                        end else begin               // From memory, one more cycle
                            mem_en     = 1'b1;
                            addr_src   = cpu_pkg::ADDR_SRC_IMM;
                            next_state = cpu_pkg::S_EXECUTE;
                        end
                    end
                    cpu_pkg::OP_JPL: begin           // JMP when IR[11] set
                        pc_load   = 1'b1;
                        pc_src    = cpu_pkg::PC_SRC_REG;
                        link_load = ~ir[11];
                    end
                    cpu_pkg::OP_RET: begin
                        pc_load = 1'b1;
                        pc_src  = cpu_pkg::PC_SRC_LINK;
                    end
                    cpu_pkg::OP_BRD: begin
                        pc_load     = take_branch;
                        pc_src      = cpu_pkg::PC_SRC_BRANCH;
                        flags_clear = 1'b1;          // Taken or not
                    end
                    cpu_pkg::OP_ADD: begin
                        is_alu = 1'b1;
                        alu_op = cpu_pkg::ALU_ADD;
                    end
                    cpu_pkg::OP_SUB: begin
                        is_alu = 1'b1;
                        alu_op = cpu_pkg::ALU_SUB;
                    end
                    cpu_pkg::OP_AND: begin
                        is_alu = 1'b1;
                        alu_op = cpu_pkg::ALU_AND;
                    end
                    cpu_pkg::OP_OR: begin
                        is_alu = 1'b1;
                        alu_op = cpu_pkg::ALU_OR;
                    end
                    cpu_pkg::OP_XOR: begin
                        is_alu = 1'b1;
                        alu_op = cpu_pkg::ALU_XOR;
                    end
                    default: ;                       // NOP and unused codes
                endcase
                if (is_alu) begin
                    flags_load = 1'b1;               // Flags always, CMP included
                    if (!ir[8]) begin                // Destination kept
                        alu_load     = 1'b1;
                        alu_pend_set = 1'b1;
                        next_state   = cpu_pkg::S_EXECUTE;
                    end
                end
            end
            cpu_pkg::S_EXECUTE: begin
                next_state = cpu_pkg::S_FETCH_ADDR;
                if (alu_pend) begin
                    reg_we = 1'b1;
                    wb_src = cpu_pkg::WB_SRC_ALU;
                end else if (opcode == cpu_pkg::OP_LD) begin
                    reg_we = 1'b1;
                    wb_src = cpu_pkg::WB_SRC_MEM;
                end else begin
                    out_load = 1'b1;                 // OUT from memory
                end
            end
            default: next_state = cpu_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= cpu_pkg::S_IDLE;
            ir       <= '0;
            alu_pend <= 1'b0;
            halted   <= 1'b0;
        end else begin
            state    <= next_state;
            alu_pend <= alu_pend_set;
            if (ir_load) ir <= mem_rdata;
            if (halt_set) begin
                halted <= 1'b1;
            end else if (state == cpu_pkg::S_IDLE && start) begin
                halted <= 1'b0;                      // Held until next start
            end
        end
    end

    // Register file and memory never written in one cycle
    a_one_writer: assert property (@(posedge Clk) disable iff (!rst_n)
        !(reg_we && mem_we));

    a_state_legal: assert property (@(posedge Clk) disable iff (!rst_n)
        state inside {cpu_pkg::S_IDLE, cpu_pkg::S_CLEAR, cpu_pkg::S_FETCH_ADDR,
                      cpu_pkg::S_FETCH_IR, cpu_pkg::S_DECODE, cpu_pkg::S_EXECUTE});

endmodule

//--- pc_unit.sv
`timescale 1ns/1ps

module pc_unit (
    input  logic              Clk,
    input  logic              rst_n,
    input  logic              pc_clear,
    input  logic              pc_inc,
    input  logic              pc_load,
    input  logic              link_load,
    input  cpu_pkg::pc_src_t  pc_src,
    input  cpu_pkg::offset_t  branch_offset,
    input  cpu_pkg::word_t    jump_target,
    output cpu_pkg::addr_t    pc
);

    cpu_pkg::addr_t link;      // Return address for RET
    cpu_pkg::addr_t pc_next;

    // Next PC select with PC already past the current instruction
    always_comb begin
        case (pc_src)
            cpu_pkg::PC_SRC_INC:    pc_next = pc + 1'b1;
            cpu_pkg::PC_SRC_BRANCH: pc_next = pc + cpu_pkg::addr_t'(branch_offset);  // Wraps mod 512
            cpu_pkg::PC_SRC_REG:    pc_next = cpu_pkg::addr_t'(jump_target);         // Low bits of rs1
            default:                pc_next = link;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_clear) begin
            pc <= '0;
        end else if (pc_inc || pc_load) begin
            pc <= pc_next;                // pc_src stays INC during FETCH_IR
        end
    end

    // JPL saves the incremented PC
    always_ff @(posedge Clk) begin
        if (link_load) link <= pc;
    end

endmodule

//--- reg_bank.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_bank (
    input  logic               Clk,
    input  logic               rst_n,
    input  logic               reg_we,
    input  cpu_pkg::wb_src_t   wb_src,
    input  cpu_pkg::reg_idx_t  rd_idx,
    input  cpu_pkg::reg_idx_t  rs1_idx,
    input  cpu_pkg::reg_idx_t  rs2_idx,
    input  cpu_pkg::addr_t     imm,
    input  cpu_pkg::word_t     mem_rdata,
    input  cpu_pkg::word_t     alu_result,
    input  logic               out_load,
    input  cpu_pkg::out_src_t  out_src,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    output cpu_pkg::word_t     out_data,
    output logic               out_valid
);

    cpu_pkg::word_t regs [1 << `CPU_REG_IDX_W];
    cpu_pkg::word_t wb_data;

    // Write-back source
    always_comb begin
        case (wb_src)
            cpu_pkg::WB_SRC_IMM: wb_data = cpu_pkg::word_t'(imm);  // Zero-extended
            cpu_pkg::WB_SRC_MEM: wb_data = mem_rdata;
            default:             wb_data = alu_result;
        endcase
    end

    assign rs1_data = regs[rs1_idx];  // Async read ports
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `CPU_REG_IDX_W); i++) regs[i] <= '0;
            out_data  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (reg_we) regs[rd_idx] <= wb_data;
            if (out_load) out_data <= (out_src == cpu_pkg::OUT_SRC_REG) ? rs1_data : mem_rdata;
            out_valid <= out_load;            // Pulse with the new value
        end
    end

endmodule

//--- alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
    input  logic              Clk,
    input  logic              rst_n,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    input  logic              alu_load,
    input  logic              flags_load,
    input  logic              flags_clear,
    output cpu_pkg::word_t    result,
    output cpu_pkg::flags_t   flags
);

    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0] sum;     // Carry in top bit
    cpu_pkg::word_t       res_c;
    logic                 carry_c;
    logic                 ovf_c;

    always_comb begin
        sum     = '0;
        carry_c = 1'b0;            // Logic ops clear C and V
        ovf_c   = 1'b0;
        case (alu_op)
            cpu_pkg::ALU_ADD: begin
                sum     = {1'b0, a} + {1'b0, b};
                res_c   = sum[MSB:0];
                carry_c = sum[MSB+1];
                ovf_c   = (a[MSB] == b[MSB]) && (res_c[MSB] != a[MSB]);
            end
            cpu_pkg::ALU_SUB: begin
                sum     = {1'b0, a} + {1'b0, ~b} + 1'b1;
                res_c   = sum[MSB:0];
                carry_c = sum[MSB+1];  // Not-borrow
                ovf_c   = (a[MSB] != b[MSB]) && (res_c[MSB] != a[MSB]);
            end
            cpu_pkg::ALU_AND: res_c = a & b;
            cpu_pkg::ALU_OR:  res_c = a | b;
            default:          res_c = a ^ b;
        endcase
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flags_clear) begin   // Clear wins
            flags <= '0;
        end else if (flags_load) begin
            flags <= {ovf_c, res_c[MSB], carry_c, (res_c == '0)};
        end
    end

    always_ff @(posedge Clk) begin
        if (alu_load) result <= res_c;
    end

endmodule

//--- cpu_mem.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_mem (
    input  logic                Clk,
    input  logic                mem_en,
    input  logic                mem_we,
    input  cpu_pkg::addr_src_t  addr_src,
    input  cpu_pkg::addr_t      pc,
    input  cpu_pkg::addr_t      imm,
    input  cpu_pkg::word_t      wdata,
    input  logic                prog_we,
    input  cpu_pkg::addr_t      prog_addr,
    input  cpu_pkg::word_t      prog_wdata,
    output cpu_pkg::word_t      rdata
);

    cpu_pkg::word_t mem [`CPU_MEM_DEPTH];
    cpu_pkg::addr_t addr;

    assign addr = (addr_src == cpu_pkg::ADDR_SRC_IMM) ? imm : pc;

    // Single port, read data one cycle after enable
    always_ff @(posedge Clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_wdata;        // Program load
        end else if (mem_en) begin
            if (mem_we) mem[addr] <= wdata;
            else rdata <= mem[addr];
        end
    end

    // Loader only runs while the core idles
    a_load_idle: assert property (@(posedge Clk) !(prog_we && mem_en));

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic            Clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            prog_we,
    input  cpu_pkg::addr_t  prog_addr,
    input  cpu_pkg::word_t  prog_wdata,
    output cpu_pkg::word_t  out_data,
    output logic            out_valid,
    output logic            halted,
    output logic            busy
);

    // ------------------------------------------------------------------
    // Control wires
    // ------------------------------------------------------------------
    logic               pc_clear, pc_inc, pc_load, link_load;
    cpu_pkg::pc_src_t   pc_src;
    cpu_pkg::offset_t   branch_offset;
    logic               mem_en, mem_we;
    cpu_pkg::addr_src_t addr_src;
    cpu_pkg::addr_t     imm;
    logic               reg_we, out_load;
    cpu_pkg::wb_src_t   wb_src;
    cpu_pkg::reg_idx_t  rd_idx, rs1_idx, rs2_idx;
    cpu_pkg::out_src_t  out_src;
    cpu_pkg::alu_op_t   alu_op;
    logic               alu_load, flags_load, flags_clear;

    // Datapath wires
    cpu_pkg::addr_t     pc;
    cpu_pkg::word_t     mem_rdata, alu_result, rs1_data, rs2_data;
    cpu_pkg::flags_t    flags;
    logic               prog_we_idle;

    assign prog_we_idle = prog_we & ~busy;   // Load port only while idle

    seq_control i_seq_control (
        .Clk, .rst_n, .start, .mem_rdata, .flags, .busy, .halted,
        .pc_clear, .pc_inc, .pc_load, .link_load, .pc_src, .branch_offset,
        .mem_en, .mem_we, .addr_src, .imm,
        .reg_we, .wb_src, .rd_idx, .rs1_idx, .rs2_idx, .out_load, .out_src,
        .alu_op, .alu_load, .flags_load, .flags_clear
    );

    pc_unit i_pc_unit (
        .Clk, .rst_n, .pc_clear, .pc_inc, .pc_load, .link_load,
        .pc_src, .branch_offset,
        .jump_target (rs1_data),
        .pc
    );

    reg_bank i_reg_bank (
        .Clk, .rst_n, .reg_we, .wb_src, .rd_idx, .rs1_idx, .rs2_idx, .imm,
        .mem_rdata, .alu_result, .out_load, .out_src,
        .rs1_data, .rs2_data, .out_data, .out_valid
    );

    alu i_alu (
        .Clk, .rst_n, .alu_op,
        .a      (rs1_data),
        .b      (rs2_data),
        .alu_load, .flags_load, .flags_clear,
        .result (alu_result),
        .flags
    );

    cpu_mem i_cpu_mem (
        .Clk, .mem_en, .mem_we, .addr_src, .pc, .imm,
        .wdata      (rs1_data),               // ST data
        .prog_we    (prog_we_idle),
        .prog_addr, .prog_wdata,
        .rdata      (mem_rdata)
    );

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int MAX_TESTS = 16;
    localparam int MARGIN    = 50;          // Load, start and idle slack per test

    logic               Clk;
    logic               rst_n;
    logic               start;
    logic               prog_we;
    cpu_pkg::addr_t     prog_addr;
    cpu_pkg::word_t     prog_wdata;
    cpu_pkg::word_t     out_data;
    logic               out_valid;
    logic               halted;
    logic               busy;

    // Golden data indexed per test into flat queues
    string              names [MAX_TESTS];
    int                 prog_first [MAX_TESTS];
    int                 prog_cnt [MAX_TESTS];
    int                 out_first [MAX_TESTS];
    int                 out_cnt [MAX_TESTS];
    int                 exp_cycles [MAX_TESTS];
    cpu_pkg::addr_t     prog_addrs [$];
    cpu_pkg::word_t     prog_words [$];
    cpu_pkg::word_t     exp_outs [$];
    int                 fields [$];         // Hex numbers of the current line
    int                 ntests;
    int                 fail_tests;
    int                 file_errors;
    int                 cycle_count;
    int                 cycle_limit;

    cpu_top i_cpu_top (
        .Clk, .rst_n, .start, .prog_we, .prog_addr, .prog_wdata,
        .out_data, .out_valid, .halted, .busy
    );

    initial begin
        Clk = 1'b0;
        forever #10 Clk = ~Clk;             // 20 ns period
    end

    // Run guard with a limit known once the golden file is read
    always @(posedge Clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the core never reached halted", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Golden file parsing
    // ------------------------------------------------------------------
    function automatic bit is_blank(input byte c);
        return c == " " || c == "\t" || c == "\n" || c == "\r";
    endfunction

    function automatic int hex_value(input byte c);
        if (c >= "0" && c <= "9") return int'(c) - 48;
        if (c >= "A" && c <= "F") return int'(c) - 55;
        if (c >= "a" && c <= "f") return int'(c) - 87;
        return -1;                          // Separator
    endfunction

    // Hex numbers after the tag character
    function automatic void split_fields(input string s);
        int v;
        int digit;
        bit in_num;
        fields.delete();
        v = 0;
        in_num = 1'b0;
        for (int i = 1; i < s.len(); i++) begin
            digit = hex_value(s.getc(i));
            if (digit >= 0) begin
                v = v * 16 + digit;
                in_num = 1'b1;
            end else if (in_num) begin
                fields.push_back(v);
                v = 0;
                in_num = 1'b0;
            end
        end
        if (in_num) fields.push_back(v);    // Last line without newline
    endfunction

    function automatic string name_field(input string s);
        int first;
        int last;
        first = 1;
        while (first < s.len() && is_blank(s.getc(first))) first++;
        last = first;
        while (last < s.len() && !is_blank(s.getc(last))) last++;
        return s.substr(first, last - 1);
    endfunction

    task automatic read_golden();
        int    fd;
        int    t;
        byte   tag;
        string line;
        ntests = 0;
        fd = $fopen("cpu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file cpu_golden.txt");
            file_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) continue;
            tag = line.getc(0);
            if (tag == "#" || is_blank(tag)) continue;    // Comment or blank
            split_fields(line);
            t = ntests - 1;
            if (tag == "T" && ntests < MAX_TESTS) begin
                names[ntests]      = name_field(line);
                prog_first[ntests] = prog_words.size();
                prog_cnt[ntests]   = 0;
                out_first[ntests]  = exp_outs.size();
                out_cnt[ntests]    = 0;
                exp_cycles[ntests] = 0;
                ntests++;
            end else if (tag == "P" && t >= 0 && fields.size() > 1) begin
                for (int i = 1; i < fields.size(); i++) begin
                    prog_addrs.push_back(cpu_pkg::addr_t'(fields[0] + i - 1));
                    prog_words.push_back(cpu_pkg::word_t'(fields[i]));
                    prog_cnt[t]++;
                end
            end else if (tag == "O" && t >= 0) begin
                foreach (fields[i]) exp_outs.push_back(cpu_pkg::word_t'(fields[i]));
                out_cnt[t] += fields.size();
            end else if (tag == "C" && t >= 0 && fields.size() == 1) begin
                exp_cycles[t] = fields[0];
            end else begin
                $display("golden file line not understood: %s", line);
                file_errors++;
            end
        end
        $fclose(fd);
    endtask

    // Worst test plus slack for every test and the reset
    function automatic int timeout_limit();
        int worst;
        worst = 0;
        for (int t = 0; t < ntests; t++) begin
            if (exp_cycles[t] + prog_cnt[t] > worst) worst = exp_cycles[t] + prog_cnt[t];
        end
        return (worst + MARGIN) * (ntests + 1);
    endfunction

    // ------------------------------------------------------------------
    // Stimulus and checks
    // ------------------------------------------------------------------
    task automatic load_program(input int t);
        for (int i = 0; i < prog_cnt[t]; i++) begin
            @(negedge Clk);
            prog_we    = 1'b1;
            prog_addr  = prog_addrs[prog_first[t] + i];
            prog_wdata = prog_words[prog_first[t] + i];
        end
        @(negedge Clk);
        prog_we = 1'b0;
    endtask

    task automatic run_test(input int t);
        cpu_pkg::word_t got [$];
        cpu_pkg::word_t want;
        int             errors;
        int             cycles;
        bit             done;
        errors = 0;
        if (busy !== 1'b0) begin
            $display("test %s: the core is still busy before the program load", names[t]);
            errors++;
        end
        load_program(t);
        @(negedge Clk);
        start  = 1'b1;                      // Start cycle is cycle 0
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge Clk);
            start = 1'b0;
            cycles++;
            if (out_valid === 1'b1) got.push_back(out_data);
            done = (halted === 1'b1);
        end
        if (busy !== 1'b0) begin
            $display("error: busy got %h expected 0", busy);
            errors++;
        end
        if (cycles != exp_cycles[t]) begin
            $display("error: halted cycle count got 0x%0h expected 0x%0h",
                     cycles, exp_cycles[t]);
            errors++;
        end
        if (got.size() != out_cnt[t]) begin
            $display("test %s: %0d OUT results seen where %0d were expected",
                     names[t], got.size(), out_cnt[t]);
            errors++;
        end
        for (int i = 0; i < got.size() && i < out_cnt[t]; i++) begin
            want = exp_outs[out_first[t] + i];
            if (got[i] !== want) begin
                $display("error: out_data[%0d] got %h expected %h", i, got[i], want);
                errors++;
            end
        end
        if (errors == 0) begin
            $display("test %s: ok, %0d cycles", names[t], cycles);
        end else begin
            $display("test %s: FAIL, %0d errors", names[t], errors);
            fail_tests++;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        start       = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_wdata  = '0;
        fail_tests  = 0;
        file_errors = 0;
        cycle_count = 0;
        cycle_limit = 0;
        read_golden();
        cycle_limit = timeout_limit();
        repeat (8) @(posedge Clk);          // Reset for 8 cycles
        @(negedge Clk);
        rst_n = 1'b1;
        for (int t = 0; t < ntests; t++) run_test(t);   // Each one reloads after HLT
        $display("tests %0d, passed %0d, failed %0d, golden file errors %0d",
                 ntests, ntests - fail_tests, fail_tests, file_errors);
        if (ntests > 0 && fail_tests == 0 && file_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- cpu_golden.txt
# T name | P start address, then program words | O expected OUT values in order
# C cycles from the start cycle to the first cycle with halted high | numbers in hex
T alu_ops
P 000 22F5 243C 9621 5803 A812 5804 BA21 5805 CC21 5806 DE21 5807 A721 5803 1000
O 0131 FF47 0034 00FD 00C9 0131
C 34

T store_load
P 000 23A5 9611 4701 4300 3500 5802 5100 3901 5804 1000
O 01A5 01A5 034A
C 24

T branches
P 000 2205 2409 28AA 2AFF A610 A111 8002 5805 8401 5804
P 00A A121 8002 5805 8401 5804 A121 8402 5805 8401 5804
P 014 A111 8402 5805 8401 5804 A121 8802 5805 8401 5804
P 01E A112 8802 5805 8401 5804 9123 8C02 5805 8401 5804
P 028 A121 8C02 5805 8401 5804 1000
O 00AA 00FF 00AA 00FF 00AA 00FF 00AA 00FF
C 69

T call_jump
P 000 2210 2408 2611 6001 2822 5804 6802 5803 2A33 5805 6001 1000
P 010 5803 7000
O 0011 0022 0033 0011
C 2F

T reload
P 000 2DFF 9C66 5806 AE60 5807 1000
O 03FE FC02
C 16

//--- all.f
+incdir+.
cpu_pkg.sv
seq_control.sv
pc_unit.sv
reg_bank.sv
alu.sv
cpu_mem.sv
cpu_top.sv
tb_cpu.sv

//--- Makefile
TOP = tb_cpu

all: run

build:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module cpu_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
